// File: design/lsu_pkg.sv
/*
 * load/store unit definitions
 * operation kinds, RV32 funct3 size codes and alignment helpers
 */
package lsu_pkg;

    // operation kind handed over by the upstream stage
    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,
        OP_LOAD  = 3'd1,
        OP_STORE = 3'd2
    } mem_op_e;

    // funct3 of the load/store instruction, ISA encoding
    typedef logic [2:0] mem_funct_t;

    localparam mem_funct_t FUNCT_LB  = 3'b000;
    localparam mem_funct_t FUNCT_LH  = 3'b001;
    localparam mem_funct_t FUNCT_LW  = 3'b010;
    localparam mem_funct_t FUNCT_LBU = 3'b100;
    localparam mem_funct_t FUNCT_LHU = 3'b101;
    localparam mem_funct_t FUNCT_SB  = 3'b000;
    localparam mem_funct_t FUNCT_SH  = 3'b001;
    localparam mem_funct_t FUNCT_SW  = 3'b010;

    // access size lives in funct3[1:0]
    localparam logic [1:0] SIZE_HALF = 2'b01;
    localparam logic [1:0] SIZE_WORD = 2'b10;

    function automatic logic [1:0] access_size(mem_funct_t funct);
        return funct[1:0];
    endfunction

    // halfword needs bit 0 clear, word needs both low bits clear
    function automatic logic misaligned(mem_funct_t funct, logic [1:0] addr_lo);
        case (access_size(funct))
            SIZE_HALF: return addr_lo[0];
            SIZE_WORD: return |addr_lo;
            default:   return 1'b0;
        endcase
    endfunction

endpackage

// File: design/axi_lite_pkg.sv
/*
 * AXI-lite common definitions
 * response codes and bus widths for master and slave
 */
package axi_lite_pkg;

    // data bus width and its byte strobe width
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    // only the two responses this system produces
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

endpackage

// File: design/lsu_ctrl.sv
/*
 * load/store control
 * accepts one operation at a time, runs the AXI-lite read or write
 * and returns the result with a one-cycle done pulse
 */
`timescale 1ns/1ps

module lsu_ctrl #(
    parameter int ADDR_W = 32
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   op_valid_i,
    input  lsu_pkg::mem_op_e       op_kind_i,
    input  lsu_pkg::mem_funct_t    op_funct_i,
    input  logic [ADDR_W-1:0]      op_addr_i,
    input  logic [31:0]            op_wdata_i,
    input  logic [4:0]             rd_i,
    input  logic [31:0]            load_data_i,
    input  logic                   arready_i,
    input  logic                   rvalid_i,
    input  axi_lite_pkg::axi_resp_t rresp_i,
    input  logic                   awready_i,
    input  logic                   wready_i,
    input  logic                   bvalid_i,
    input  axi_lite_pkg::axi_resp_t bresp_i,
    output logic                   op_ready_o,
    output logic                   done_valid_o,
    output logic [4:0]             rd_o,
    output logic [31:0]            wb_data_o,
    output logic                   fault_o,
    output logic [ADDR_W-1:0]      acc_addr_o,
    output lsu_pkg::mem_funct_t    acc_funct_o,
    output logic [31:0]            acc_wdata_o,
    output logic [ADDR_W-1:0]      araddr_o,
    output logic                   arvalid_o,
    output logic                   rready_o,
    output logic [ADDR_W-1:0]      awaddr_o,
    output logic                   awvalid_o,
    output logic                   wvalid_o,
    output logic                   bready_o
);
    import lsu_pkg::*;
    import axi_lite_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_RESP,
        ST_DONE
    } state_e;

    state_e            state_q;
    mem_op_e           kind_q;
    mem_funct_t        funct_q;
    logic [ADDR_W-1:0] addr_q;
    logic [31:0]       wdata_q;
    logic [4:0]        rd_q;
    logic [31:0]       res_q;
    logic              fault_q;
    // write address and write data may complete in different cycles
    logic              aw_done_q;
    logic              w_done_q;

    logic accept;
    logic is_mem;
    logic bad_align;
    logic ar_hs;
    logic r_hs;
    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic aw_ok;
    logic w_ok;

    assign op_ready_o = (state_q == ST_IDLE);
    assign accept     = op_valid_i && op_ready_o;
    assign is_mem     = (op_kind_i == OP_LOAD) || (op_kind_i == OP_STORE);
    assign bad_align  = is_mem && misaligned(op_funct_i, op_addr_i[1:0]);

    // bus channels, driven from the captured operation
    assign arvalid_o = (state_q == ST_ADDR) && (kind_q == OP_LOAD);
    assign awvalid_o = (state_q == ST_ADDR) && (kind_q == OP_STORE) && !aw_done_q;
    assign wvalid_o  = (state_q == ST_ADDR) && (kind_q == OP_STORE) && !w_done_q;
    assign rready_o  = (state_q == ST_RESP) && (kind_q == OP_LOAD);
    assign bready_o  = (state_q == ST_RESP) && (kind_q == OP_STORE);
    assign araddr_o  = addr_q;
    assign awaddr_o  = addr_q;

    assign ar_hs = arvalid_o && arready_i;
    assign r_hs  = rready_o && rvalid_i;
    assign aw_hs = awvalid_o && awready_i;
    assign w_hs  = wvalid_o && wready_i;
    assign b_hs  = bready_o && bvalid_i;
    assign aw_ok = aw_done_q || aw_hs;
    assign w_ok  = w_done_q || w_hs;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= ST_IDLE;
            fault_q   <= 1'b0;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        // pass-through and misaligned go straight to done
                        state_q <= (is_mem && !bad_align) ? ST_ADDR : ST_DONE;
                        fault_q <= bad_align;
                    end
                end
                ST_ADDR: begin
                    if (kind_q == OP_LOAD) begin
                        if (ar_hs) begin
                            state_q <= ST_RESP;
                        end
                    end else if (aw_ok && w_ok) begin
                        state_q   <= ST_RESP;
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                    end else begin
                        aw_done_q <= aw_ok;
                        w_done_q  <= w_ok;
                    end
                end
                ST_RESP: begin
                    if (r_hs) begin
                        state_q <= ST_DONE;
                        fault_q <= (rresp_i != RESP_OKAY);
                    end else if (b_hs) begin
                        state_q <= ST_DONE;
                        fault_q <= (bresp_i != RESP_OKAY);
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // captured operation and result
    always_ff @(posedge clk) begin
        if (accept) begin
            kind_q  <= op_kind_i;
            funct_q <= op_funct_i;
            addr_q  <= op_addr_i;
            wdata_q <= op_wdata_i;
            rd_q    <= rd_i;
            // alu value is the result unless a load replaces it
            res_q   <= 32'(op_addr_i);
        end else if (r_hs) begin
            res_q <= load_data_i;
        end
    end

    assign acc_addr_o   = addr_q;
    assign acc_funct_o  = funct_q;
    assign acc_wdata_o  = wdata_q;
    assign done_valid_o = (state_q == ST_DONE);
    assign rd_o         = rd_q;
    assign wb_data_o    = res_q;
    assign fault_o      = fault_q;

endmodule

// File: design/store_align.sv
/*
 * store lane alignment
 * replicates store bytes onto their lanes and builds the write strobe
 */
`timescale 1ns/1ps

module store_align (
    input  logic [1:0]          acc_addr_i,
    input  lsu_pkg::mem_funct_t acc_funct_i,
    input  logic [31:0]         acc_wdata_i,
    output logic [31:0]         wdata_o,
    output logic [3:0]          wstrb_o
);
    import lsu_pkg::*;

    always_comb begin
        case (acc_funct_i)
            FUNCT_SB: begin
                // byte copied to every lane, strobe picks one
                wdata_o = {4{acc_wdata_i[7:0]}};
                wstrb_o = 4'b0001 << acc_addr_i;
            end
            FUNCT_SH: begin
                // lower or upper halfword pair
                wdata_o = {2{acc_wdata_i[15:0]}};
                wstrb_o = acc_addr_i[1] ? 4'b1100 : 4'b0011;
            end
            FUNCT_SW: begin
                wdata_o = acc_wdata_i;
                wstrb_o = 4'b1111;
            end
            default: begin
                // not a store encoding, write nothing
                wdata_o = acc_wdata_i;
                wstrb_o = 4'b0000;
            end
        endcase
    end

endmodule

// File: design/load_extract.sv
/*
 * load data extraction
 * moves the addressed byte or halfword to bit 0 and extends it
 */
`timescale 1ns/1ps

module load_extract (
    input  logic [1:0]          acc_addr_i,
    input  lsu_pkg::mem_funct_t acc_funct_i,
    input  logic [31:0]         rdata_i,
    output logic [31:0]         load_data_o
);
    import lsu_pkg::*;

    logic [31:0] shifted;

    // byte offset times eight
    assign shifted = rdata_i >> {acc_addr_i, 3'b000};

    always_comb begin
        case (acc_funct_i)
            FUNCT_LB: begin
                load_data_o = {{24{shifted[7]}}, shifted[7:0]};
            end
            FUNCT_LH: begin
                load_data_o = {{16{shifted[15]}}, shifted[15:0]};
            end
            FUNCT_LBU: begin
                load_data_o = {24'd0, shifted[7:0]};
            end
            FUNCT_LHU: begin
                load_data_o = {16'd0, shifted[15:0]};
            end
            FUNCT_LW: begin
                load_data_o = rdata_i;
            end
            default: begin
                // unused encodings read the raw word
                load_data_o = rdata_i;
            end
        endcase
    end

endmodule

// File: design/axi_lite_sram.sv
/*
 * AXI-lite SRAM slave
 * word memory with byte strobes, one transaction per channel at a time,
 * SLVERR for addresses beyond MEM_DEPTH words
 */
`timescale 1ns/1ps

module axi_lite_sram #(
    parameter int ADDR_W    = 32,
    parameter int MEM_DEPTH = 64
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [ADDR_W-1:0]                  araddr_i,
    input  logic                               arvalid_i,
    output logic                               arready_o,
    output logic [axi_lite_pkg::AXI_DATA_W-1:0] rdata_o,
    output axi_lite_pkg::axi_resp_t            rresp_o,
    output logic                               rvalid_o,
    input  logic                               rready_i,
    input  logic [ADDR_W-1:0]                  awaddr_i,
    input  logic                               awvalid_i,
    output logic                               awready_o,
    input  logic [axi_lite_pkg::AXI_DATA_W-1:0] wdata_i,
    input  logic [axi_lite_pkg::AXI_STRB_W-1:0] wstrb_i,
    input  logic                               wvalid_i,
    output logic                               wready_o,
    output axi_lite_pkg::axi_resp_t            bresp_o,
    output logic                               bvalid_o,
    input  logic                               bready_i
);
    import axi_lite_pkg::*;

    localparam int IDX_W = $clog2(MEM_DEPTH);

    logic [AXI_DATA_W-1:0] mem [MEM_DEPTH];

    logic                  aw_held_q;
    logic                  w_held_q;
    logic [ADDR_W-1:0]     awaddr_q;
    logic [AXI_DATA_W-1:0] wdata_q;
    logic [AXI_STRB_W-1:0] wstrb_q;

    logic                  ar_hs;
    logic                  aw_hs;
    logic                  w_hs;
    logic                  wr_fire;
    logic [ADDR_W-1:0]     wr_addr;
    logic [AXI_DATA_W-1:0] wr_data;
    logic [AXI_STRB_W-1:0] wr_strb;

    // word index must fall below the depth
    function automatic logic in_range(logic [ADDR_W-1:0] addr);
        return (addr >> 2) < ADDR_W'(MEM_DEPTH);
    endfunction

    // ready while no response is pending on that side
    assign arready_o = !rvalid_o;
    assign awready_o = !aw_held_q && !bvalid_o;
    assign wready_o  = !w_held_q && !bvalid_o;

    assign ar_hs = arvalid_i && arready_o;
    assign aw_hs = awvalid_i && awready_o;
    assign w_hs  = wvalid_i && wready_o;

    // write once both halves are held or arriving this cycle
    assign wr_fire = (aw_held_q || aw_hs) && (w_held_q || w_hs);
    assign wr_addr = aw_held_q ? awaddr_q : awaddr_i;
    assign wr_data = w_held_q ? wdata_q : wdata_i;
    assign wr_strb = w_held_q ? wstrb_q : wstrb_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_fire && in_range(wr_addr)) begin
            for (int b = 0; b < AXI_STRB_W; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_addr[IDX_W+1:2]][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    // channel state
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid_o  <= 1'b0;
            bvalid_o  <= 1'b0;
            aw_held_q <= 1'b0;
            w_held_q  <= 1'b0;
        end else begin
            if (ar_hs) begin
                rvalid_o <= 1'b1;
            end else if (rready_i) begin
                rvalid_o <= 1'b0;
            end
            if (wr_fire) begin
                bvalid_o  <= 1'b1;
                aw_held_q <= 1'b0;
                w_held_q  <= 1'b0;
            end else begin
                if (bready_i) begin
                    bvalid_o <= 1'b0;
                end
                aw_held_q <= aw_held_q || aw_hs;
                w_held_q  <= w_held_q || w_hs;
            end
        end
    end

    // read data and responses
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata_o <= in_range(araddr_i) ? mem[araddr_i[IDX_W+1:2]] : '0;
            rresp_o <= in_range(araddr_i) ? RESP_OKAY : RESP_SLVERR;
        end
        if (wr_fire) begin
            bresp_o <= in_range(wr_addr) ? RESP_OKAY : RESP_SLVERR;
        end
        if (aw_hs) begin
            awaddr_q <= awaddr_i;
        end
        if (w_hs) begin
            wdata_q <= wdata_i;
            wstrb_q <= wstrb_i;
        end
    end

endmodule

// File: design/lsu_top.sv
/*
 * load/store unit top
 * control FSM, store and load datapaths and the AXI-lite SRAM
 */
`timescale 1ns/1ps

module lsu_top #(
    parameter int ADDR_W    = 32,
    parameter int MEM_DEPTH = 64
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                op_valid_i,
    input  lsu_pkg::mem_op_e    op_kind_i,
    input  lsu_pkg::mem_funct_t op_funct_i,
    input  logic [ADDR_W-1:0]   op_addr_i,
    input  logic [31:0]         op_wdata_i,
    input  logic [4:0]          rd_i,
    output logic                op_ready_o,
    output logic                done_valid_o,
    output logic [4:0]          rd_o,
    output logic [31:0]         wb_data_o,
    output logic                fault_o
);
    import lsu_pkg::*;
    import axi_lite_pkg::*;

    // captured operation
    logic [ADDR_W-1:0]     acc_addr;
    mem_funct_t            acc_funct;
    logic [31:0]           acc_wdata;
    logic [31:0]           load_data;

    // AXI-lite channels
    logic [ADDR_W-1:0]     araddr;
    logic                  arvalid;
    logic                  arready;
    logic [AXI_DATA_W-1:0] rdata;
    axi_resp_t             rresp;
    logic                  rvalid;
    logic                  rready;
    logic [ADDR_W-1:0]     awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [AXI_DATA_W-1:0] wdata;
    logic [AXI_STRB_W-1:0] wstrb;
    logic                  wvalid;
    logic                  wready;
    axi_resp_t             bresp;
    logic                  bvalid;
    logic                  bready;

    lsu_ctrl #(
        .ADDR_W (ADDR_W)
    ) i_ctrl (
        .clk          (clk),
        .rst          (rst),
        .op_valid_i   (op_valid_i),
        .op_kind_i    (op_kind_i),
        .op_funct_i   (op_funct_i),
        .op_addr_i    (op_addr_i),
        .op_wdata_i   (op_wdata_i),
        .rd_i         (rd_i),
        .load_data_i  (load_data),
        .arready_i    (arready),
        .rvalid_i     (rvalid),
        .rresp_i      (rresp),
        .awready_i    (awready),
        .wready_i     (wready),
        .bvalid_i     (bvalid),
        .bresp_i      (bresp),
        .op_ready_o   (op_ready_o),
        .done_valid_o (done_valid_o),
        .rd_o         (rd_o),
        .wb_data_o    (wb_data_o),
        .fault_o      (fault_o),
        .acc_addr_o   (acc_addr),
        .acc_funct_o  (acc_funct),
        .acc_wdata_o  (acc_wdata),
        .araddr_o     (araddr),
        .arvalid_o    (arvalid),
        .rready_o     (rready),
        .awaddr_o     (awaddr),
        .awvalid_o    (awvalid),
        .wvalid_o     (wvalid),
        .bready_o     (bready)
    );

    // only the byte offset matters to the lane logic
    store_align i_store_align (
        .acc_addr_i  (acc_addr[1:0]),
        .acc_funct_i (acc_funct),
        .acc_wdata_i (acc_wdata),
        .wdata_o     (wdata),
        .wstrb_o     (wstrb)
    );

    load_extract i_load_extract (
        .acc_addr_i  (acc_addr[1:0]),
        .acc_funct_i (acc_funct),
        .rdata_i     (rdata),
        .load_data_o (load_data)
    );

    axi_lite_sram #(
        .ADDR_W    (ADDR_W),
        .MEM_DEPTH (MEM_DEPTH)
    ) i_sram (
        .clk       (clk),
        .rst       (rst),
        .araddr_i  (araddr),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .rdata_o   (rdata),
        .rresp_o   (rresp),
        .rvalid_o  (rvalid),
        .rready_i  (rready),
        .awaddr_i  (awaddr),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .wdata_i   (wdata),
        .wstrb_i   (wstrb),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .bresp_o   (bresp),
        .bvalid_o  (bvalid),
        .bready_i  (bready)
    );

endmodule

// File: verification/lsu_tb_table.svh
/*
 * load/store unit test table
 * one row per operation, applied in order by the testbench loop
 */
`ifndef LSU_TB_TABLE_SVH
`define LSU_TB_TABLE_SVH

// kind, funct3, address or alu value, store data, rd, random store data flag
typedef struct packed {
    mem_op_e     kind;
    mem_funct_t  funct;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [4:0]  rd;
    logic        rnd;
} op_row_t;

localparam int NUM_ROWS = 48;

op_row_t op_rows [NUM_ROWS] = '{
    // pass-through
    '{OP_NONE,  FUNCT_LW,  32'h1234_5678, 32'h0000_0000, 5'd1,  1'b0},
    '{OP_NONE,  FUNCT_LW,  32'hdead_beef, 32'h0000_0000, 5'd2,  1'b0},
    // every byte has its top bit set
    '{OP_STORE, FUNCT_SW,  32'h0000_0010, 32'hf182_c394, 5'd3,  1'b0},
    '{OP_LOAD,  FUNCT_LW,  32'h0000_0010, 32'h0000_0000, 5'd4,  1'b0},
    '{OP_LOAD,  FUNCT_LB,  32'h0000_0010, 32'h0000_0000, 5'd5,  1'b0},
    '{OP_LOAD,  FUNCT_LB,  32'h0000_0011, 32'h0000_0000, 5'd6,  1'b0},
    '{OP_LOAD,  FUNCT_LB,  32'h0000_0012, 32'h0000_0000, 5'd7,  1'b0},
    '{OP_LOAD,  FUNCT_LB,  32'h0000_0013, 32'h0000_0000, 5'd8,  1'b0},
    '{OP_LOAD,  FUNCT_LBU, 32'h0000_0010, 32'h0000_0000, 5'd9,  1'b0},
    '{OP_LOAD,  FUNCT_LBU, 32'h0000_0011, 32'h0000_0000, 5'd10, 1'b0},
    '{OP_LOAD,  FUNCT_LBU, 32'h0000_0012, 32'h0000_0000, 5'd11, 1'b0},
    '{OP_LOAD,  FUNCT_LBU, 32'h0000_0013, 32'h0000_0000, 5'd12, 1'b0},
    '{OP_LOAD,  FUNCT_LH,  32'h0000_0010, 32'h0000_0000, 5'd13, 1'b0},
    '{OP_LOAD,  FUNCT_LH,  32'h0000_0012, 32'h0000_0000, 5'd14, 1'b0},
    '{OP_LOAD,  FUNCT_LHU, 32'h0000_0010, 32'h0000_0000, 5'd15, 1'b0},
    '{OP_LOAD,  FUNCT_LHU, 32'h0000_0012, 32'h0000_0000, 5'd16, 1'b0},
    // byte and halfword lanes
    '{OP_STORE, FUNCT_SW,  32'h0000_0020, 32'h1122_3344, 5'd17, 1'b0},
    '{OP_STORE, FUNCT_SB,  32'h0000_0020, 32'h0000_55aa, 5'd18, 1'b0},
    '{OP_STORE, FUNCT_SB,  32'h0000_0021, 32'h7766_99bb, 5'd19, 1'b0},
    '{OP_LOAD,  FUNCT_LW,  32'h0000_0020, 32'h0000_0000, 5'd20, 1'b0},
    '{OP_STORE, FUNCT_SB,  32'h0000_0022, 32'h0000_00cc, 5'd21, 1'b0},
    '{OP_STORE, FUNCT_SB,  32'h0000_0023, 32'hffff_ffdd, 5'd22, 1'b0},
    '{OP_LOAD,  FUNCT_LW,  32'h0000_0020, 32'h0000_0000, 5'd23, 1'b0},
    '{OP_STORE, FUNCT_SH,  32'h0000_0024, 32'hcafe_1357, 5'd24, 1'b0},
    '{OP_STORE, FUNCT_SH,  32'h0000_0026, 32'h0bad_f00d, 5'd25, 1'b0},
    '{OP_LOAD,  FUNCT_LW,  32'h0000_0024, 32'h0000_0000, 5'd26, 1'b0},
    // misaligned, memory must stay as it was
    '{OP_LOAD,  FUNCT_LH,  32'h0000_0011, 32'h0000_0000, 5'd27, 1'b0},
    '{OP_LOAD,  FUNCT_LW,  32'h0000_0012, 32'h0000_0000, 5'd28, 1'b0},
    '{OP_STORE, FUNCT_SH,  32'h0000_0013, 32'h0000_eeee, 5'd29, 1'b0},
    '{OP_STORE, FUNCT_SW,  32'h0000_0021, 32'h5555_5555, 5'd30, 1'b0},
    '{OP_LOAD,  FUNCT_LW,  32'h0000_0010, 32'h0000_0000, 5'd31, 1'b0},
    '{OP_LOAD,  FUNCT_LW,  32'h0000_0020, 32'h0000_0000, 5'd0,  1'b0},
    // word 0 gets a pattern that its out-of-range aliases would return
    '{OP_STORE, FUNCT_SW,  32'h0000_0000, 32'ha5c3_5a3c, 5'd14, 1'b0},
    // beyond the 256-byte memory
    '{OP_STORE, FUNCT_SW,  32'h0000_0100, 32'h1234_abcd, 5'd1,  1'b0},
    '{OP_LOAD,  FUNCT_LW,  32'h0000_0100, 32'h0000_0000, 5'd2,  1'b0},
    '{OP_STORE, FUNCT_SB,  32'h0000_01ff, 32'h0000_0077, 5'd3,  1'b0},
    '{OP_LOAD,  FUNCT_LB,  32'h0000_0104, 32'h0000_0000, 5'd4,  1'b0},
    '{OP_LOAD,  FUNCT_LHU, 32'h0000_03fe, 32'h0000_0000, 5'd5,  1'b0},
    '{OP_LOAD,  FUNCT_LW,  32'h8000_0000, 32'h0000_0000, 5'd6,  1'b0},
    // aliased words untouched by the stores above
    '{OP_LOAD,  FUNCT_LW,  32'h0000_0000, 32'h0000_0000, 5'd15, 1'b0},
    '{OP_LOAD,  FUNCT_LW,  32'h0000_00fc, 32'h0000_0000, 5'd16, 1'b0},
    // random store data
    '{OP_STORE, FUNCT_SW,  32'h0000_0030, 32'h0000_0000, 5'd7,  1'b1},
    '{OP_LOAD,  FUNCT_LW,  32'h0000_0030, 32'h0000_0000, 5'd8,  1'b0},
    '{OP_STORE, FUNCT_SH,  32'h0000_0036, 32'h0000_0000, 5'd9,  1'b1},
    '{OP_STORE, FUNCT_SB,  32'h0000_0035, 32'h0000_0000, 5'd10, 1'b1},
    '{OP_LOAD,  FUNCT_LW,  32'h0000_0034, 32'h0000_0000, 5'd11, 1'b0},
    // last word in range
    '{OP_STORE, FUNCT_SW,  32'h0000_00fc, 32'h8765_4321, 5'd12, 1'b0},
    '{OP_LOAD,  FUNCT_LH,  32'h0000_00fe, 32'h0000_0000, 5'd13, 1'b0}
};

`endif

// File: verification/lsu_tb.sv
/*
 * load/store unit testbench
 * applies the operation table, predicts results from a byte-wide
 * shadow memory and checks result, fault, rd and handshake timing
 */
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;

    `include "lsu_tb_table.svh"

    // cycles allowed for any single wait
    localparam int TIMEOUT = 50;

    logic        clk;
    logic        rst;
    logic        op_valid;
    mem_op_e     op_kind;
    mem_funct_t  op_funct;
    logic [31:0] op_addr;
    logic [31:0] op_wdata;
    logic [4:0]  rd;
    logic        op_ready;
    logic        done_valid;
    logic [4:0]  rd_out;
    logic [31:0] wb_data;
    logic        fault;

    // 64 words of 4 bytes, zero like the SRAM after reset
    logic [7:0] shadow [256] = '{default: 8'h00};

    lsu_top #(
        .ADDR_W    (32),
        .MEM_DEPTH (64)
    ) i_dut (
        .clk          (clk),
        .rst          (rst),
        .op_valid_i   (op_valid),
        .op_kind_i    (op_kind),
        .op_funct_i   (op_funct),
        .op_addr_i    (op_addr),
        .op_wdata_i   (op_wdata),
        .rd_i         (rd),
        .op_ready_o   (op_ready),
        .done_valid_o (done_valid),
        .rd_o         (rd_out),
        .wb_data_o    (wb_data),
        .fault_o      (fault)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out waiting for %s at %0t", what, $time);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped by timeout");
    endtask

    // halfword wants bit 0 clear, word wants both low bits clear
    function automatic logic is_misaligned(mem_funct_t funct, logic [31:0] addr);
        if (funct[1:0] == 2'b01) begin
            return addr[0];
        end
        if (funct[1:0] == 2'b10) begin
            return addr[1] | addr[0];
        end
        return 1'b0;
    endfunction

    // expected load value, zero beyond the memory
    function automatic logic [31:0] predict_load(mem_funct_t funct, logic [31:0] addr);
        logic [7:0] idx;
        logic [7:0] base;
        logic [7:0] b0;
        logic [7:0] b1;
        if (addr >= 32'd256) begin
            return 32'd0;
        end
        idx  = addr[7:0];
        base = {addr[7:2], 2'b00};
        b0   = shadow[idx];
        b1   = shadow[idx + 8'd1];
        case (funct)
            FUNCT_LB:  return {{24{b0[7]}}, b0};
            FUNCT_LBU: return {24'd0, b0};
            FUNCT_LH:  return {{16{b1[7]}}, b1, b0};
            FUNCT_LHU: return {16'd0, b1, b0};
            default: begin
                return {shadow[base + 8'd3], shadow[base + 8'd2],
                        shadow[base + 8'd1], shadow[base]};
            end
        endcase
    endfunction

    // little-endian byte writes, out-of-range stores are dropped
    task automatic apply_store(input mem_funct_t funct, input logic [31:0] addr,
                               input logic [31:0] data);
        logic [7:0] idx;
        idx = addr[7:0];
        if (addr < 32'd256) begin
            shadow[idx] = data[7:0];
            if (funct[1:0] != 2'b00) begin
                shadow[idx + 8'd1] = data[15:8];
            end
            if (funct[1:0] == 2'b10) begin
                shadow[idx + 8'd2] = data[23:16];
                shadow[idx + 8'd3] = data[31:24];
            end
        end
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!op_ready) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                report_timeout("op_ready_o");
            end
        end
    endtask

    task automatic run_row(input int n);
        op_row_t     row;
        logic [31:0] exp_data;
        logic        exp_fault;
        logic        on_bus;
        int          cycles;
        row = op_rows[n];
        if (row.rnd) begin
            row.wdata = $urandom();
        end
        // model first, the shadow holds the state before this row
        exp_data  = row.addr;
        exp_fault = 1'b0;
        on_bus    = 1'b0;
        if (row.kind != OP_NONE) begin
            if (is_misaligned(row.funct, row.addr)) begin
                exp_fault = 1'b1;
            end else begin
                on_bus    = 1'b1;
                exp_fault = (row.addr >= 32'd256);
                if (row.kind == OP_LOAD) begin
                    exp_data = predict_load(row.funct, row.addr);
                end else begin
                    apply_store(row.funct, row.addr, row.wdata);
                end
            end
        end
        wait_ready();
        op_valid = 1'b1;
        op_kind  = row.kind;
        op_funct = row.funct;
        op_addr  = row.addr;
        op_wdata = row.wdata;
        rd       = row.rd;
        // ready was high, so this edge accepts
        @(posedge clk);
        #1;
        op_valid = 1'b0;
        cycles   = 1;
        while (!done_valid) begin
            check_value("op_ready_o", 32'(op_ready), 32'd0);
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                report_timeout("done_valid_o");
            end
        end
        // no bus traffic means done in the cycle right after acceptance
        if (!on_bus) begin
            check_value("done latency", 32'(cycles), 32'd1);
        end
        check_value("op_ready_o", 32'(op_ready), 32'd0);
        check_value("rd_o", 32'(rd_out), 32'(row.rd));
        check_value("fault_o", 32'(fault), 32'(exp_fault));
        if (row.kind == OP_NONE || (row.kind == OP_LOAD && on_bus)) begin
            check_value("wb_data_o", wb_data, exp_data);
        end
        // one-cycle pulse, then back to idle
        @(posedge clk);
        #1;
        check_value("done_valid_o", 32'(done_valid), 32'd0);
        check_value("op_ready_o", 32'(op_ready), 32'd1);
    endtask

    initial begin
        void'($urandom(82472));
        op_valid = 1'b0;
        op_kind  = OP_NONE;
        op_funct = FUNCT_LW;
        op_addr  = 32'd0;
        op_wdata = 32'd0;
        rd       = 5'd0;
        rst      = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int n = 0; n < NUM_ROWS; n++) begin
            run_row(n);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: tb.f
+incdir+verification
design/lsu_pkg.sv
design/axi_lite_pkg.sv
design/lsu_ctrl.sv
design/store_align.sv
design/load_extract.sv
design/axi_lite_sram.sv
design/lsu_top.sv
verification/lsu_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the load/store unit testbench with Verilator
# a failing check ends in $fatal, which gives a non-zero exit status
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 \
    --top-module lsu_tb \
    -f tb.f \
    -o lsu_tb_sim
./obj_dir/lsu_tb_sim
